// File: Makefile
# Verilator flow for the rv64 execute unit testbench
TOP := rv_alu_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f rv_alu.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: rv_alu.f
rv_alu_pkg.sv
rv_alu_decode.sv
rv_alu_shift.sv
rv_alu_arith.sv
rv_alu_core.sv
rv_alu_exec.sv
rv_alu_checker.sv
rv_alu_tb.sv

// File: rv_alu_arith.sv
// adder/subtractor with signed and unsigned less-than taken from the same carry chain
`default_nettype none

module rv_alu_arith #(
    parameter int xlen_p = rv_alu_pkg::xlen
) (
    input  logic [xlen_p-1:0] a,
    input  logic [xlen_p-1:0] b,
    input  logic              sub,
    output logic [xlen_p-1:0] sum,
    output logic              lt_signed,
    output logic              lt_unsigned
);

    logic [xlen_p-1:0] b_eff;
    logic [xlen_p:0]   full;
    logic              carry;
    logic              a_msb;
    logic              b_msb;
    logic              s_msb;

    // a - b as a + ~b + 1
    assign b_eff = sub ? ~b : b;
    assign full  = {1'b0, a} + {1'b0, b_eff} + (xlen_p + 1)'(sub);

    assign sum   = full[xlen_p-1:0];
    assign carry = full[xlen_p];

    assign a_msb = a[xlen_p-1];
    assign b_msb = b[xlen_p-1];
    assign s_msb = full[xlen_p-1];

    // no borrow means a >= b unsigned
    assign lt_unsigned = ~carry;

    // differing signs decide directly, otherwise the difference can't overflow
    assign lt_signed = (a_msb ^ b_msb) ? a_msb : s_msb;

endmodule

`default_nettype wire

// File: rv_alu_checker.sv
// protocol assertions for the execute unit, bound into every rv_alu_exec instance in simulation
`default_nettype none

module rv_alu_checker #(
    parameter int xlen_p = rv_alu_pkg::xlen
) (
    input logic              clk,
    input logic              rst,
    input logic              in_valid,
    input logic              out_valid,
    input logic [xlen_p-1:0] result,
    input logic              illegal
);
    timeunit 1ns;
    timeprecision 1ps;

    reset_clears: assert property (@(posedge clk)
        rst |=> (!out_valid && !illegal && result == '0))
        else $error("outputs not cleared after a reset cycle");

    // fixed two-stage latency with no stalls
    latency_two: assert property (@(posedge clk) disable iff (rst)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    illegal_zero: assert property (@(posedge clk) disable iff (rst)
        illegal |-> result == '0)
        else $error("nonzero result on an illegal instruction");

    idle_zero: assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> (result == '0 && !illegal))
        else $error("result or illegal set while out_valid is low");

endmodule

bind rv_alu_exec rv_alu_checker #(.xlen_p(xlen_p)) u_checker (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result),
    .illegal   (illegal)
);

`default_nettype wire

// File: rv_alu_core.sv
// execute datapath, picks operand b, runs shifter, adder and logic ops and selects the result
`default_nettype none

module rv_alu_core #(
    parameter int xlen_p = rv_alu_pkg::xlen
) (
    input  rv_alu_pkg::alu_op_t alu_op,
    input  logic                word_op,
    input  logic                use_imm,
    input  logic [xlen_p-1:0]   imm,
    input  logic [xlen_p-1:0]   rs1_data,
    input  logic [xlen_p-1:0]   rs2_data,
    output logic [xlen_p-1:0]   alu_result
);

    import rv_alu_pkg::*;

    logic [xlen_p-1:0] op_b;
    shift_op_t         shift_op;
    logic              sub;
    logic [xlen_p-1:0] shift_result;
    logic [xlen_p-1:0] sum;
    logic              lt_signed;
    logic              lt_unsigned;
    logic [xlen_p-1:0] sum_ext;

    assign op_b = use_imm ? imm : rs2_data;

    always_comb begin
        case (alu_op)
            alu_sll: shift_op = sh_sll;
            alu_srl: shift_op = sh_srl;
            alu_sra: shift_op = sh_sra;
            default: shift_op = sh_none;
        endcase
    end

    assign sub = alu_op inside {alu_sub, alu_slt, alu_sltu}; // compares go through the subtractor

    rv_alu_shift #(.xlen_p(xlen_p)) u_shift (
        .operand      (rs1_data),
        .amount       (op_b[5:0]),
        .shift_op     (shift_op),
        .word_op      (word_op),
        .shift_result (shift_result)
    );

    rv_alu_arith #(.xlen_p(xlen_p)) u_arith (
        .a           (rs1_data),
        .b           (op_b),
        .sub         (sub),
        .sum         (sum),
        .lt_signed   (lt_signed),
        .lt_unsigned (lt_unsigned)
    );

    assign sum_ext = word_op ? xlen_p'(signed'(sum[31:0])) : sum; // addw/subw

    always_comb begin
        case (alu_op)
            alu_add, alu_sub:          alu_result = sum_ext;
            alu_sll, alu_srl, alu_sra: alu_result = shift_result;
            alu_slt:                   alu_result = xlen_p'(lt_signed);
            alu_sltu:                  alu_result = xlen_p'(lt_unsigned);
            alu_xor:                   alu_result = rs1_data ^ op_b;
            alu_or:                    alu_result = rs1_data | op_b;
            default:                   alu_result = rs1_data & op_b;
        endcase
    end

endmodule

`default_nettype wire

// File: rv_alu_decode.sv
// instruction decoder for the execute unit, maps op/op-imm and their w forms to an alu operation
`default_nettype none

module rv_alu_decode (
    input  logic [31:0]         instr,
    output rv_alu_pkg::alu_op_t alu_op,
    output logic                word_op,
    output logic                use_imm,
    output logic [63:0]         imm,
    output logic                illegal
);

    import rv_alu_pkg::*;

    instr_word_u iw;
    logic        imm_w;
    logic        sh_base;
    logic        sh_alt;

    assign iw    = instr;
    assign imm_w = (iw.i.opcode == opc_op_imm_32);

    // shift immediates carry funct6 on rv64, funct7 on w forms
    assign sh_base = imm_w ? (iw.i.imm[11:5] == f7_base) : (iw.i.imm[11:6] == f6_base);
    assign sh_alt  = imm_w ? (iw.i.imm[11:5] == f7_alt) : (iw.i.imm[11:6] == f6_alt);

    always_comb begin
        alu_op  = alu_add;
        word_op = 1'b0;
        use_imm = 1'b0;
        imm     = '0;
        illegal = 1'b0;
        case (iw.r.opcode)
            opc_op, opc_op_32: begin
                word_op = (iw.r.opcode == opc_op_32);
                if (iw.r.funct7 == f7_base) begin
                    case (iw.r.funct3)
                        f3_add_sub: alu_op = alu_add;
                        f3_sll:     alu_op = alu_sll;
                        f3_slt:     alu_op = alu_slt;
                        f3_sltu:    alu_op = alu_sltu;
                        f3_xor:     alu_op = alu_xor;
                        f3_srl_sra: alu_op = alu_srl;
                        f3_or:      alu_op = alu_or;
                        default:    alu_op = alu_and;
                    endcase
                end else if (iw.r.funct7 == f7_alt) begin
                    case (iw.r.funct3)
                        f3_add_sub: alu_op = alu_sub;
                        f3_srl_sra: alu_op = alu_sra;
                        default:    illegal = 1'b1;
                    endcase
                end else begin
                    illegal = 1'b1;
                end
            end
            opc_op_imm, opc_op_imm_32: begin
                word_op = imm_w;
                use_imm = 1'b1;
                imm     = 64'(signed'(iw.i.imm));
                case (iw.i.funct3)
                    f3_add_sub: alu_op = alu_add;
                    f3_slt:     alu_op = alu_slt;
                    f3_sltu:    alu_op = alu_sltu;
                    f3_xor:     alu_op = alu_xor;
                    f3_or:      alu_op = alu_or;
                    f3_and:     alu_op = alu_and;
                    f3_sll: begin
                        alu_op  = alu_sll;
                        illegal = !sh_base; // also catches slliw with shamt[5] set
                    end
                    default: begin
                        if (sh_base)
                            alu_op = alu_srl;
                        else if (sh_alt)
                            alu_op = alu_sra;
                        else
                            illegal = 1'b1;
                    end
                endcase
            end
            default: illegal = 1'b1;
        endcase

        // w forms only have add, sub and the shifts
        if (word_op && !(iw.r.funct3 inside {f3_add_sub, f3_sll, f3_srl_sra}))
            illegal = 1'b1;
        if (illegal)
            alu_op = alu_add;
    end

endmodule

`default_nettype wire

// File: rv_alu_exec.sv
// top of the integer execute unit, decode stage then execute stage, two cycles from issue to result
`default_nettype none

module rv_alu_exec #(
    parameter int xlen_p = rv_alu_pkg::xlen
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [31:0]       instr,
    input  logic [xlen_p-1:0] rs1_data,
    input  logic [xlen_p-1:0] rs2_data,
    output logic              out_valid,
    output logic [xlen_p-1:0] result,
    output logic              illegal
);

    import rv_alu_pkg::*;

    alu_op_t           dec_alu_op;
    logic              dec_word_op;
    logic              dec_use_imm;
    logic [63:0]       dec_imm;
    logic              dec_illegal;
    logic              dec_bad;

    logic              s1_valid;
    logic              s1_illegal;
    alu_op_t           s1_alu_op;
    logic              s1_word_op;
    logic              s1_use_imm;
    logic [xlen_p-1:0] s1_imm;
    logic [xlen_p-1:0] s1_rs1;
    logic [xlen_p-1:0] s1_rs2;
    logic [xlen_p-1:0] core_result;

    rv_alu_decode u_decode (
        .instr   (instr),
        .alu_op  (dec_alu_op),
        .word_op (dec_word_op),
        .use_imm (dec_use_imm),
        .imm     (dec_imm),
        .illegal (dec_illegal)
    );

    assign dec_bad = dec_illegal | (dec_word_op & (xlen_p < 64)); // no w forms on rv32

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            s1_illegal <= 1'b0;
        end else begin
            s1_valid   <= in_valid;
            s1_illegal <= in_valid & dec_bad;
        end
        if (in_valid) begin // operands only
            s1_alu_op  <= dec_alu_op;
            s1_word_op <= dec_word_op;
            s1_use_imm <= dec_use_imm;
            s1_imm     <= dec_imm[xlen_p-1:0];
            s1_rs1     <= rs1_data;
            s1_rs2     <= rs2_data;
        end
    end

    rv_alu_core #(.xlen_p(xlen_p)) u_core (
        .alu_op     (s1_alu_op),
        .word_op    (s1_word_op),
        .use_imm    (s1_use_imm),
        .imm        (s1_imm),
        .rs1_data   (s1_rs1),
        .rs2_data   (s1_rs2),
        .alu_result (core_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            result    <= '0;
            illegal   <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            result    <= (s1_valid && !s1_illegal) ? core_result : '0; // zero when idle or bad
            illegal   <= s1_valid & s1_illegal;
        end
    end

endmodule

`default_nettype wire

// File: rv_alu_pkg.sv
// shared encodings and instruction views for the rv64 integer execute unit, imported by each block
`default_nettype none

package rv_alu_pkg;

    parameter int xlen = 64;

    // major opcodes accepted by the unit
    parameter logic [6:0] opc_op        = 7'b0110011;
    parameter logic [6:0] opc_op_imm    = 7'b0010011;
    parameter logic [6:0] opc_op_32     = 7'b0111011;
    parameter logic [6:0] opc_op_imm_32 = 7'b0011011;

    parameter logic [2:0] f3_add_sub = 3'b000;
    parameter logic [2:0] f3_sll     = 3'b001;
    parameter logic [2:0] f3_slt     = 3'b010;
    parameter logic [2:0] f3_sltu    = 3'b011;
    parameter logic [2:0] f3_xor     = 3'b100;
    parameter logic [2:0] f3_srl_sra = 3'b101;
    parameter logic [2:0] f3_or      = 3'b110;
    parameter logic [2:0] f3_and     = 3'b111;

    parameter logic [6:0] f7_base = 7'b0000000;
    parameter logic [6:0] f7_alt  = 7'b0100000; // sub, sra
    parameter logic [5:0] f6_base = 6'b000000;  // rv64 shift immediates
    parameter logic [5:0] f6_alt  = 6'b010000;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // one-hot code for left logical, right logical and right arithmetic
    typedef enum logic [2:0] {
        sh_none = 3'b000,
        sh_sll  = 3'b100,
        sh_srl  = 3'b010,
        sh_sra  = 3'b001
    } shift_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

endpackage

`default_nettype wire

// File: rv_alu_shift.sv
// 64/32-bit shifter for sll, srl and sra, one right shifter shared through bit reversal
`default_nettype none

module rv_alu_shift #(
    parameter int xlen_p = rv_alu_pkg::xlen
) (
    input  logic [xlen_p-1:0]     operand,
    input  logic [5:0]            amount,
    input  rv_alu_pkg::shift_op_t shift_op,
    input  logic                  word_op,
    output logic [xlen_p-1:0]     shift_result
);

    localparam logic [xlen_p-1:0] low_word = xlen_p'(32'hffff_ffff);

    logic [5:0]        shamt;
    logic [xlen_p-1:0] src;
    logic [xlen_p-1:0] src_rev;
    logic [xlen_p-1:0] shift_in;
    logic [xlen_p-1:0] right_res;
    logic [xlen_p-1:0] right_rev;
    logic [xlen_p-1:0] sra_mask;
    logic [xlen_p-1:0] sraw_mask;
    logic [xlen_p-1:0] sra_res;
    logic [xlen_p-1:0] res_pre;

    assign shamt = word_op ? {1'b0, amount[4:0]} : amount;
    assign src   = word_op ? xlen_p'(operand[31:0]) : operand; // w forms see low word only

    // left shift = reverse, shift right, reverse back
    for (genvar i = 0; i < xlen_p; i++) begin : g_rev
        assign src_rev[i]   = src[xlen_p-1-i];
        assign right_rev[i] = right_res[xlen_p-1-i];
    end

    assign shift_in  = shift_op[2] ? src_rev : src;
    assign right_res = shift_in >> shamt;

    // fill masks mark the bits vacated by the right shift
    assign sra_mask  = ~({xlen_p{1'b1}} >> shamt);
    assign sraw_mask = ~(low_word >> shamt) & low_word;

    always_comb begin
        if (word_op)
            sra_res = ({xlen_p{src[31]}} & sraw_mask) | right_res;
        else
            sra_res = ({xlen_p{src[xlen_p-1]}} & sra_mask) | right_res;
    end

    always_comb begin
        if (shift_op[2])
            res_pre = right_rev;
        else if (shift_op[1])
            res_pre = right_res;
        else if (shift_op[0])
            res_pre = sra_res;
        else
            res_pre = '0; // no shift selected
    end

    assign shift_result = word_op ? xlen_p'(signed'(res_pre[31:0])) : res_pre;

endmodule

`default_nettype wire

// File: rv_alu_tb.sv
// testbench for rv_alu_exec, streams rv_alu_vectors.txt through the pipeline and checks each result
`default_nettype none

module rv_alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int xlen_p  = 64;
    localparam int max_vec = 256;

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic [31:0]       instr;
    logic [xlen_p-1:0] rs1_data;
    logic [xlen_p-1:0] rs2_data;
    logic              out_valid;
    logic [xlen_p-1:0] result;
    logic              illegal;

    logic [31:0]       vec_instr [max_vec];
    logic [xlen_p-1:0] vec_rs1   [max_vec];
    logic [xlen_p-1:0] vec_rs2   [max_vec];
    logic              vec_ill   [max_vec];
    logic [xlen_p-1:0] vec_res   [max_vec];

    int num_vec = 0;
    int cur_idx = 0;
    int checked = 0;
    int cycles  = 0;
    int limit   = 0;
    int seed    = 14;
    int pending [$]; // vector indices in flight in issue order

    rv_alu_exec #(.xlen_p(xlen_p)) u_rv_alu_exec (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .instr     (instr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .out_valid (out_valid),
        .result    (result),
        .illegal   (illegal)
    );

    task automatic stop_with_failure(input string reason);
        $display("tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic load_vectors();
        string       line;
        int          fd;
        int          fields;
        logic [31:0] t_instr;
        logic [63:0] t_rs1;
        logic [63:0] t_rs2;
        logic [31:0] t_ill;
        logic [63:0] t_res;
        fd = $fopen("rv_alu_vectors.txt", "r");
        if (fd == 0)
            stop_with_failure("cannot open rv_alu_vectors.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#")
                continue; // blank or comment
            fields = $sscanf(line, "%h %h %h %h %h", t_instr, t_rs1, t_rs2, t_ill, t_res);
            if (fields != 5)
                stop_with_failure("malformed line in rv_alu_vectors.txt");
            if (num_vec == max_vec)
                stop_with_failure("too many vectors in rv_alu_vectors.txt");
            vec_instr[num_vec] = t_instr;
            vec_rs1[num_vec]   = t_rs1;
            vec_rs2[num_vec]   = t_rs2;
            vec_ill[num_vec]   = t_ill[0];
            vec_res[num_vec]   = t_res;
            num_vec++;
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("run stopped at %0t after %0d cycles with %0d results outstanding",
                     $time, cycles, pending.size());
            stop_with_failure("simulation timed out");
        end
    end

    // outputs and in_valid are both settled mid-cycle
    always @(negedge clk) begin
        int idx;
        if (!rst && out_valid) begin
            if (pending.size() == 0)
                stop_with_failure("out_valid was raised with no instruction in flight");
            idx = pending.pop_front();
            assert (illegal === vec_ill[idx]) else begin
                $display("[ERROR] time %0t signal illegal expected %0b actual %0b (vector %0d)",
                         $time, vec_ill[idx], illegal, idx);
                stop_with_failure("illegal flag mismatch");
            end
            assert (result === vec_res[idx]) else begin
                $display("[ERROR] time %0t signal result expected %h actual %h (vector %0d)",
                         $time, vec_res[idx], result, idx);
                stop_with_failure("result mismatch");
            end
            checked++;
        end
        if (!rst && in_valid)
            pending.push_back(cur_idx);
    end

    initial begin
        in_valid = 1'b0;
        instr    = '0;
        rs1_data = '0;
        rs2_data = '0;
        rst      = 1'b1;
        load_vectors();
        if (num_vec == 0)
            stop_with_failure("no vectors found in rv_alu_vectors.txt");
        limit = 2 * num_vec + 50;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int k = 0; k < num_vec; k++) begin
            if (($random(seed) & 3) == 0) begin
                in_valid = 1'b0; // idle gap
                @(posedge clk);
                #1;
            end
            cur_idx  = k;
            in_valid = 1'b1;
            instr    = vec_instr[k];
            rs1_data = vec_rs1[k];
            rs2_data = vec_rs2[k];
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        instr    = '0;
        rs1_data = '0;
        rs2_data = '0;
        repeat (4) @(posedge clk); // two cycles of latency plus room for a stray out_valid
        if (pending.size() != 0 || checked != num_vec)
            stop_with_failure($sformatf("only %0d of %0d results came back", checked, num_vec));
        else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rv_alu_vectors.txt
# instr rs1 rs2 illegal result, all hex, one instruction per line
# register forms use rd=x1 rs1=x2 rs2=x3, immediates sit in instr
003100B3 0000000000000005 0000000000000003 0 0000000000000008
003100B3 7FFFFFFFFFFFFFFF 0000000000000001 0 8000000000000000
403100B3 0000000000000003 0000000000000005 0 FFFFFFFFFFFFFFFE
00510093 FFFFFFFFFFFFFFFF 0000000000000000 0 0000000000000004
80010093 0000000000000000 0000000000000000 0 FFFFFFFFFFFFF800
003140B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0 0FF00FF00FF00FF0
003160B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0 FFF0FFF0FFF0FFF0
003170B3 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 0 F000F000F000F000
FFF14093 0123456789ABCDEF 0000000000000000 0 FEDCBA9876543210
0F016093 1234567800000000 0000000000000000 0 12345678000000F0
FF017093 123456789ABCDEFF 0000000000000000 0 123456789ABCDEF0
00000000 0000000000000001 0000000000000001 1 0000000000000000
# compares
003120B3 FFFFFFFFFFFFFFFF 0000000000000001 0 0000000000000001
003130B3 FFFFFFFFFFFFFFFF 0000000000000001 0 0000000000000000
003120B3 0000000000000001 FFFFFFFFFFFFFFFF 0 0000000000000000
003130B3 0000000000000001 FFFFFFFFFFFFFFFF 0 0000000000000001
003120B3 8000000000000000 7FFFFFFFFFFFFFFF 0 0000000000000001
FFF12093 FFFFFFFFFFFFFFFE 0000000000000000 0 0000000000000001
FFF13093 0000000000000000 0000000000000000 0 0000000000000001
00113093 FFFFFFFFFFFFFFFF 0000000000000000 0 0000000000000000
023100B3 0000000000000001 0000000000000001 1 0000000000000000
# shifts, rs2 bits above bit 5 set
003110B3 8000000000000001 FFFFFFFFFFFFFFC0 0 8000000000000001
003110B3 8000000000000001 FFFFFFFFFFFFFFC1 0 0000000000000002
003110B3 8000000000000001 FFFFFFFFFFFFFFE0 0 0000000100000000
003110B3 8000000000000001 FFFFFFFFFFFFFFFF 0 8000000000000000
003150B3 8000000000000001 FFFFFFFFFFFFFFC1 0 4000000000000000
003150B3 8000000000000001 FFFFFFFFFFFFFFDF 0 0000000100000000
003150B3 8000000000000001 FFFFFFFFFFFFFFFF 0 0000000000000001
403150B3 8000000000000001 FFFFFFFFFFFFFFC0 0 8000000000000001
403150B3 8000000000000001 FFFFFFFFFFFFFFE0 0 FFFFFFFF80000000
403150B3 8000000000000001 FFFFFFFFFFFFFFFF 0 FFFFFFFFFFFFFFFF
01F11093 8000000000000001 0000000000000000 0 0000000080000000
02015093 8000000000000001 0000000000000000 0 0000000080000000
41F15093 8000000000000001 0000000000000000 0 FFFFFFFF00000000
40115093 7FFFFFFFFFFFFFFF 0000000000000000 0 3FFFFFFFFFFFFFFF
43F15093 7FFFFFFFFFFFFFFF 0000000000000000 0 0000000000000000
0201109B 0000000000000001 0000000000000000 1 0000000000000000
# word forms
003100BB 123456787FFFFFFF 0000000000000001 0 FFFFFFFF80000000
403100BB FFFFFFFF00000000 0000000000000001 0 FFFFFFFFFFFFFFFF
003110BB 0000000000000001 FFFFFFFFFFFFFFFF 0 FFFFFFFF80000000
003150BB FFFFFFFF80000000 FFFFFFFFFFFFFFE0 0 FFFFFFFF80000000
003150BB 1234567880000000 0000000000000001 0 0000000040000000
403150BB 1234567880000000 FFFFFFFFFFFFFFFF 0 FFFFFFFFFFFFFFFF
01F1109B 0000000000000003 0000000000000000 0 FFFFFFFF80000000
0041509B FFFFFFFF80000000 0000000000000000 0 0000000008000000
4041509B 0000000080000000 0000000000000000 0 FFFFFFFFF8000000
003140BB 0000000000000001 0000000000000001 1 0000000000000000
003100B3 0000000000000002 0000000000000002 0 0000000000000004
